// File: hw/calc_pkg.sv
`default_nettype none

package calc_pkg;

   localparam int DATA_W    = 8; // Width of every byte on the serial link and in the ALU.
   localparam int OPERAND_W = 4; // Only the low nibble of an operand byte is used.

   typedef logic [DATA_W-1:0]    data_t;    // One serial byte or one ALU word.
   typedef logic [OPERAND_W-1:0] operand_t; // The used part of an operand byte.

   // ASCII codes of the four accepted operator characters.
   localparam data_t CHAR_ADD = 8'd43;  // The '+' character.
   localparam data_t CHAR_SUB = 8'd45;  // The '-' character.
   localparam data_t CHAR_AND = 8'd38;  // The '&' character.
   localparam data_t CHAR_OR  = 8'd124; // The '|' character.

   typedef enum logic [2:0] {
      ALU_NOP, // Unknown operator, result is zero.
      ALU_ADD, // Sum modulo 256.
      ALU_SUB, // Difference modulo 256.
      ALU_AND, // Bitwise and.
      ALU_OR   // Bitwise or.
   } alu_op_e;

   typedef enum logic [2:0] {
      SEQ_LOAD_A,  // Waiting for operand A.
      SEQ_LOAD_OP, // Waiting for the operator character.
      SEQ_LOAD_B,  // Waiting for operand B.
      SEQ_EXECUTE, // Single cycle that latches the result and starts the transmitter.
      SEQ_WAIT_TX  // Result frame is on the line.
   } seq_state_e;

   typedef struct packed {
      data_t   operand_a; // Zero-extended low nibble of operand A.
      data_t   operand_b; // Zero-extended low nibble of operand B.
      alu_op_e op;        // Decoded operation.
   } alu_req_t;

endpackage

`default_nettype wire

// File: hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

   localparam int CLKS_PER_TICK = 4;  // Kept small so a bit lasts only 64 clocks.
   localparam int TICKS_PER_BIT = 16; // Oversampling rate of both directions.
   localparam int BIT_CNT_W     = 3;  // Counts the eight data bits.
   localparam int TICK_CNT_W    = 4;  // Counts ticks inside one bit.
   localparam int DIV_CNT_W     = $clog2(CLKS_PER_TICK); // Width of the tick divider.

   typedef logic [DIV_CNT_W-1:0]  div_cnt_t;  // Clock count inside one tick.
   typedef logic [TICK_CNT_W-1:0] tick_cnt_t; // Tick count inside one bit.
   typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;  // Index of the current data bit.

   localparam div_cnt_t  DIV_LAST = div_cnt_t'(CLKS_PER_TICK - 1);    // Last clock of a tick.
   localparam tick_cnt_t TICK_MID = tick_cnt_t'(TICKS_PER_BIT/2 - 1); // Middle of a bit.
   localparam tick_cnt_t TICK_END = tick_cnt_t'(TICKS_PER_BIT - 1);   // Last tick of a bit.

   typedef enum logic [1:0] {
      RX_IDLE, RX_START, RX_DATA, RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE, TX_START, TX_DATA, TX_STOP
   } tx_state_e;

endpackage

`default_nettype wire

// File: hw/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
   input  wire  i_clk,
   input  wire  i_rx_done,
   output logic o_tick
);

   uart_pkg::div_cnt_t div_cnt; // Free-running clock divider.

   always_ff @(posedge i_clk or posedge i_rx_done) begin
      if (i_rx_done) begin
         div_cnt <= '0; // Restart the divider so the first tick is a full period away.
      end else if (div_cnt == uart_pkg::DIV_LAST) begin
         div_cnt <= '0; // Wrap at the end of the tick period.
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // One-cycle pulse on the last clock of each period, shared by receiver and transmitter.
   assign o_tick = (div_cnt == uart_pkg::DIV_LAST);

endmodule

`default_nettype wire

// File: hw/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
   input  wire             i_clk,
   input  wire             i_rx_done,
   input  wire             i_tick,
   input  wire             i_rx,
   output calc_pkg::data_t o_byte,
   output logic            o_byte_valid,
   output logic            o_frame_error
);

   uart_pkg::rx_state_e state;
   uart_pkg::tick_cnt_t tick_cnt; // Ticks seen in the current bit.
   uart_pkg::bit_cnt_t  bit_cnt;  // Data bits already sampled.
   calc_pkg::data_t     shreg;    // Data bits, filled from the top.
   logic [2:0]          rx_pipe;  // Two synchronizer flops and one history flop.
   logic                rx_sync;
   logic                rx_fall;
   logic                bit_end;
   logic                data_sample;

   assign rx_sync     = rx_pipe[1];                          // Line value safe to use.
   assign rx_fall     = rx_pipe[2] & ~rx_pipe[1];            // A high to low step may start a frame.
   assign bit_end     = i_tick && (tick_cnt == uart_pkg::TICK_END); // Middle of a data bit.
   assign data_sample = (state == uart_pkg::RX_DATA) && bit_end;

   always_ff @(posedge i_clk or posedge i_rx_done) begin
      if (i_rx_done) begin
         rx_pipe <= '1; // The idle line is high.
      end else begin
         rx_pipe <= {rx_pipe[1:0], i_rx};
      end
   end

   always_ff @(posedge i_clk or posedge i_rx_done) begin
      if (i_rx_done) begin
         state         <= uart_pkg::RX_IDLE;
         tick_cnt      <= '0;
         bit_cnt       <= '0;
         o_byte_valid  <= 1'b0;
         o_frame_error <= 1'b0;
      end else begin
         o_byte_valid  <= 1'b0; // Both flags are single-cycle pulses.
         o_frame_error <= 1'b0;
         case (state)
            uart_pkg::RX_IDLE: begin
               if (rx_fall) begin
                  state    <= uart_pkg::RX_START;
                  tick_cnt <= '0; // Count half a bit from the edge.
               end
            end
            uart_pkg::RX_START: begin
               if (i_tick && (tick_cnt == uart_pkg::TICK_MID)) begin
                  tick_cnt <= '0; // From here on every sample falls mid-bit.
                  bit_cnt  <= '0;
                  // A line that is high again was only a glitch.
                  state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
               end else if (i_tick) begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end
            uart_pkg::RX_DATA: begin
               if (bit_end) begin
                  tick_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == '1) state <= uart_pkg::RX_STOP; // The eighth bit is in.
               end else if (i_tick) begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end
            uart_pkg::RX_STOP: begin
               if (bit_end) begin
                  tick_cnt      <= '0;
                  o_byte_valid  <= rx_sync;  // A high stop bit delivers the byte.
                  o_frame_error <= ~rx_sync; // A low stop bit discards it.
                  state         <= uart_pkg::RX_IDLE;
               end else if (i_tick) begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end
            default: state <= uart_pkg::RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (data_sample) begin
         shreg <= {rx_sync, shreg[calc_pkg::DATA_W-1:1]}; // LSB arrives first.
      end
   end

   assign o_byte = shreg; // Stable from the last data sample until the next frame.

   // Tick counting assumes that every tick is a single-clock pulse.
   assert property (@(posedge i_clk) disable iff (i_rx_done)
      i_tick |=> !i_tick);

endmodule

`default_nettype wire

// File: hw/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter (
   input  wire             i_clk,
   input  wire             i_rx_done,
   input  wire             i_tick,
   input  wire             i_start,
   input  wire calc_pkg::data_t i_byte,
   output logic            o_tx,
   output logic            o_done
);

   uart_pkg::tx_state_e state;
   uart_pkg::tick_cnt_t tick_cnt;   // Ticks spent in the current bit.
   uart_pkg::bit_cnt_t  bit_cnt;    // Data bits already sent.
   calc_pkg::data_t     shreg;      // Bit 0 is the bit on the line.
   logic                start_pend; // Start seen, waiting for a tick to align the frame.
   logic                bit_end;

   assign bit_end = i_tick && (tick_cnt == uart_pkg::TICK_END); // Last tick of a bit.

   always_ff @(posedge i_clk or posedge i_rx_done) begin
      if (i_rx_done) begin
         state      <= uart_pkg::TX_IDLE;
         tick_cnt   <= '0;
         bit_cnt    <= '0;
         start_pend <= 1'b0;
         o_done     <= 1'b0;
      end else begin
         o_done <= 1'b0; // Single-cycle pulse.
         if (i_tick && (state != uart_pkg::TX_IDLE)) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
         end
         case (state)
            uart_pkg::TX_IDLE: begin
               if (i_start) begin
                  start_pend <= 1'b1;
               end else if (start_pend && i_tick) begin
                  start_pend <= 1'b0;
                  tick_cnt   <= '0; // The start bit begins on a tick boundary.
                  state      <= uart_pkg::TX_START;
               end
            end
            uart_pkg::TX_START: begin
               if (bit_end) begin
                  bit_cnt <= '0;
                  state   <= uart_pkg::TX_DATA;
               end
            end
            uart_pkg::TX_DATA: begin
               if (bit_end) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == '1) state <= uart_pkg::TX_STOP; // All eight bits are out.
               end
            end
            uart_pkg::TX_STOP: begin
               if (bit_end) begin
                  o_done <= 1'b1; // The stop bit has lasted its full period.
                  state  <= uart_pkg::TX_IDLE;
               end
            end
            default: state <= uart_pkg::TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if ((state == uart_pkg::TX_IDLE) && i_start) begin
         shreg <= i_byte; // Capture the byte while the caller still drives it.
      end else if ((state == uart_pkg::TX_DATA) && bit_end) begin
         shreg <= shreg >> 1; // Move the next bit to position 0.
      end
   end

   always_comb begin
      case (state)
         uart_pkg::TX_START: o_tx = 1'b0;
         uart_pkg::TX_DATA:  o_tx = shreg[0];
         default:            o_tx = 1'b1; // Idle and stop both hold the line high.
      endcase
   end

   // The sequencer must not start a new frame before the previous one is done.
   assert property (@(posedge i_clk) disable iff (i_rx_done)
      i_start |-> (state == uart_pkg::TX_IDLE) && !start_pend);

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire calc_pkg::alu_req_t i_req,
   output calc_pkg::data_t         o_result
);

   always_comb begin
      case (i_req.op)
         calc_pkg::ALU_ADD: o_result = i_req.operand_a + i_req.operand_b; // Wraps at 256.
         calc_pkg::ALU_SUB: o_result = i_req.operand_a - i_req.operand_b; // Wraps below 0.
         calc_pkg::ALU_AND: o_result = i_req.operand_a & i_req.operand_b;
         calc_pkg::ALU_OR:  o_result = i_req.operand_a | i_req.operand_b;
         default:           o_result = '0; // Unknown operators give zero.
      endcase
   end

endmodule

`default_nettype wire

// File: hw/command_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module command_sequencer (
   input  wire                 i_clk,
   input  wire                 i_rx_done,
   input  wire calc_pkg::data_t i_rx_byte,
   input  wire                 i_rx_valid,
   input  wire calc_pkg::data_t i_alu_result,
   input  wire                 i_tx_done,
   output calc_pkg::alu_req_t  o_alu_req,
   output calc_pkg::data_t     o_tx_byte,
   output logic                o_tx_start
);

   calc_pkg::seq_state_e       state;
   calc_pkg::data_t [2:0]      regs;    // After three loads entry 2 is A, 1 the operator, 0 B.
   calc_pkg::data_t            tx_byte; // Result held for the whole response frame.
   calc_pkg::operand_t         nib_a;
   calc_pkg::operand_t         nib_b;
   logic                       loading;

   assign loading = (state == calc_pkg::SEQ_LOAD_A)  ||
                    (state == calc_pkg::SEQ_LOAD_OP) ||
                    (state == calc_pkg::SEQ_LOAD_B);   // Bytes are accepted only here.

   always_ff @(posedge i_clk or posedge i_rx_done) begin
      if (i_rx_done) begin
         state   <= calc_pkg::SEQ_LOAD_A;
         regs    <= '0;
         tx_byte <= '0;
      end else begin
         if (loading && i_rx_valid) begin
            regs <= {regs[1:0], i_rx_byte}; // Older bytes move up one entry.
         end
         case (state)
            calc_pkg::SEQ_LOAD_A: begin
               if (i_rx_valid) state <= calc_pkg::SEQ_LOAD_OP;
            end
            calc_pkg::SEQ_LOAD_OP: begin
               if (i_rx_valid) state <= calc_pkg::SEQ_LOAD_B;
            end
            calc_pkg::SEQ_LOAD_B: begin
               if (i_rx_valid) state <= calc_pkg::SEQ_EXECUTE;
            end
            calc_pkg::SEQ_EXECUTE: begin
               tx_byte <= i_alu_result; // Operands are stable, so the result is final.
               state   <= calc_pkg::SEQ_WAIT_TX;
            end
            calc_pkg::SEQ_WAIT_TX: begin
               if (i_tx_done) state <= calc_pkg::SEQ_LOAD_A; // Ready for the next command.
            end
            default: state <= calc_pkg::SEQ_LOAD_A;
         endcase
      end
   end

   assign nib_a = regs[2][calc_pkg::OPERAND_W-1:0]; // Digits carry their value here.
   assign nib_b = regs[0][calc_pkg::OPERAND_W-1:0];

   always_comb begin
      o_alu_req.operand_a = calc_pkg::data_t'(nib_a); // Zero-extended to a full byte.
      o_alu_req.operand_b = calc_pkg::data_t'(nib_b);
      case (regs[1])
         calc_pkg::CHAR_ADD: o_alu_req.op = calc_pkg::ALU_ADD;
         calc_pkg::CHAR_SUB: o_alu_req.op = calc_pkg::ALU_SUB;
         calc_pkg::CHAR_AND: o_alu_req.op = calc_pkg::ALU_AND;
         calc_pkg::CHAR_OR:  o_alu_req.op = calc_pkg::ALU_OR;
         default:            o_alu_req.op = calc_pkg::ALU_NOP;
      endcase
   end

   // The transmitter captures its byte during the start pulse, so the fresh result is
   // passed straight through in that cycle.
   assign o_tx_byte  = (state == calc_pkg::SEQ_EXECUTE) ? i_alu_result : tx_byte;
   assign o_tx_start = (state == calc_pkg::SEQ_EXECUTE);

   // The receiver strobe lasts one clock, so every byte is stored only once.
   assert property (@(posedge i_clk) disable iff (i_rx_done)
      i_rx_valid |=> !i_rx_valid);

   // A done pulse only arrives while the sequencer waits for the response.
   assert property (@(posedge i_clk) disable iff (i_rx_done)
      i_tx_done |-> (state == calc_pkg::SEQ_WAIT_TX));

endmodule

`default_nettype wire

// File: hw/uart_calculator_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_calculator_top (
   input  wire  i_clk,
   input  wire  i_rx_done,
   input  wire  i_rx,
   output logic o_tx,
   output logic o_frame_error
);

   logic               tick;       // Oversampling tick for both directions.
   logic               rx_valid;   // Received byte is ready.
   logic               tx_start;   // Start of the response frame.
   logic               tx_done;    // End of the response frame.
   calc_pkg::data_t    rx_byte;
   calc_pkg::data_t    alu_result;
   calc_pkg::data_t    tx_byte;
   calc_pkg::alu_req_t alu_req;

   baud_tick_gen u_tick_gen (
      .i_clk     (i_clk),
      .i_rx_done (i_rx_done),
      .o_tick    (tick)
   );

   uart_receiver u_receiver (
      .i_clk         (i_clk),
      .i_rx_done     (i_rx_done),
      .i_tick        (tick),
      .i_rx          (i_rx),
      .o_byte        (rx_byte),
      .o_byte_valid  (rx_valid),
      .o_frame_error (o_frame_error)
   );

   command_sequencer u_sequencer (
      .i_clk        (i_clk),
      .i_rx_done    (i_rx_done),
      .i_rx_byte    (rx_byte),
      .i_rx_valid   (rx_valid),
      .i_alu_result (alu_result),
      .i_tx_done    (tx_done),
      .o_alu_req    (alu_req),
      .o_tx_byte    (tx_byte),
      .o_tx_start   (tx_start)
   );

   alu u_alu (
      .i_req    (alu_req),
      .o_result (alu_result)
   );

   uart_transmitter u_transmitter (
      .i_clk     (i_clk),
      .i_rx_done (i_rx_done),
      .i_tick    (tick),
      .i_start   (tx_start),
      .i_byte    (tx_byte),
      .o_tx      (o_tx),
      .o_done    (tx_done)
   );

endmodule

`default_nettype wire

// File: verification/calc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module calc_checker (
   input wire                  i_clk,
   input wire                  i_rx_done,
   input wire                  i_tx,
   input wire                  i_frame_error,
   input wire                  i_push,
   input wire calc_pkg::data_t i_push_byte,
   input wire                  i_expect_ferr
);

   localparam int BIT_CLKS = uart_pkg::CLKS_PER_TICK * uart_pkg::TICKS_PER_BIT; // 64 clocks.
   localparam int HALF_BIT = BIT_CLKS / 2; // Offset from the falling edge to the bit centres.

   calc_pkg::data_t expected_q[$];  // Results still owed by the DUT, oldest first.
   calc_pkg::data_t got;            // Byte being decoded from o_tx.
   calc_pkg::data_t want;
   int              pending_count = 0;  // Read by the testbench to know when all results are in.
   int              mismatch_count = 0;
   int              protocol_count = 0;
   int              ferr_seen = 0;
   int              ferr_expected = 0;
   int              clk_cnt = 0;        // Clocks since the start bit was seen.
   int              bit_no;
   logic            busy = 1'b0;        // A result frame is being decoded.

   always @(posedge i_clk) begin
      if (i_push) expected_q.push_back(i_push_byte); // The testbench announces a result.
      if (i_expect_ferr) ferr_expected++;            // A bad stop bit is about to be sent.
      if (!i_rx_done && i_frame_error) begin
         ferr_seen++;
         if (ferr_seen > ferr_expected) begin
            protocol_count++;
            $display("o_frame_error pulsed at %0t ns but no frame with a low stop bit was sent",
                     $time);
         end
      end
      if (!busy) begin
         busy    = !i_rx_done && !i_tx; // A low line marks a start bit.
         clk_cnt = 0;
      end else begin
         clk_cnt++;
         if ((clk_cnt == HALF_BIT) && i_tx) begin
            protocol_count++; // The line rose again, so this was no start bit.
            $display("o_tx went low but was high again in the middle of the start bit at %0t ns",
                     $time);
            busy = 1'b0;
         end else if ((clk_cnt > HALF_BIT) && ((clk_cnt - HALF_BIT) % BIT_CLKS == 0)) begin
            bit_no = (clk_cnt - HALF_BIT) / BIT_CLKS; // Data bits are 1 to 8, the stop bit is 9.
            if (bit_no <= 8) begin
               got = {i_tx, got[7:1]}; // LSB first, so bits enter at the top.
            end else begin
               busy = 1'b0;
               if (!i_tx) begin
                  protocol_count++;
                  $display("The stop bit of a result frame on o_tx was low at %0t ns", $time);
               end
               if (expected_q.size() == 0) begin
                  protocol_count++; // Nothing was owed, so the DUT sent a frame on its own.
                  $display("A frame 0x%02h appeared on o_tx at %0t ns with no result expected",
                           got, $time);
               end else begin
                  want = expected_q.pop_front();
                  if (got !== want) begin
                     mismatch_count++;
                     $display("** Error at %0t ns: o_tx byte 0x%02h, expected 0x%02h",
                              $time, got, want);
                  end
               end
            end
         end
      end
      pending_count = expected_q.size();
   end

endmodule

`default_nettype wire

// File: verification/tb_uart_calculator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_calculator;

   localparam int BIT_CLKS    = uart_pkg::CLKS_PER_TICK * uart_pkg::TICKS_PER_BIT; // 64 clocks.
   localparam int DRAIN_LIMIT = 20 * BIT_CLKS; // A result needs well under two frames.

   logic            i_clk;
   logic            i_rx_done;
   logic            i_rx;
   logic            o_tx;
   logic            o_frame_error;
   logic            push;          // Hands one expected result to the checker.
   calc_pkg::data_t push_byte;
   logic            expect_ferr;   // Tells the checker a bad stop bit is coming.
   logic [31:0]     lfsr_state = 32'hbfa9943a;
   int              tb_errors = 0;
   calc_pkg::data_t a;
   calc_pkg::data_t op;
   calc_pkg::data_t b;
   logic [7:0]      r;

   uart_calculator_top uut (
      .i_clk         (i_clk),
      .i_rx_done     (i_rx_done),
      .i_rx          (i_rx),
      .o_tx          (o_tx),
      .o_frame_error (o_frame_error)
   );

   calc_checker u_checker (
      .i_clk         (i_clk),
      .i_rx_done     (i_rx_done),
      .i_tx          (o_tx),
      .i_frame_error (o_frame_error),
      .i_push        (push),
      .i_push_byte   (push_byte),
      .i_expect_ferr (expect_ferr)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk; // 20 ns period.
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2 and 1.
   endfunction

   task automatic take_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state); // One step for every bit taken.
         val        = {val[6:0], lfsr_state[0]};
      end
   endtask

   task automatic random_digit(output calc_pkg::data_t d);
      logic [7:0] v;
      take_bits(4, v);
      d = calc_pkg::data_t'(48 + v % 10); // ASCII '0' to '9'.
   endtask

   function automatic calc_pkg::data_t pick_operator(input logic [1:0] sel);
      case (sel)
         2'd0:    return calc_pkg::CHAR_ADD;
         2'd1:    return calc_pkg::CHAR_SUB;
         2'd2:    return calc_pkg::CHAR_AND;
         default: return calc_pkg::CHAR_OR;
      endcase
   endfunction

   function automatic calc_pkg::data_t expected_result(input calc_pkg::data_t x,
         input calc_pkg::data_t opc, input calc_pkg::data_t y);
      int na;
      int nb;
      int res;
      na = x % 16; // Only the low nibble of an operand counts.
      nb = y % 16;
      if (opc == calc_pkg::CHAR_ADD) res = na + nb;
      else if (opc == calc_pkg::CHAR_SUB) res = (na - nb + 256) % 256; // Wraps below zero.
      else if (opc == calc_pkg::CHAR_AND) res = na & nb;
      else if (opc == calc_pkg::CHAR_OR) res = na | nb;
      else res = 0; // Any other character.
      return calc_pkg::data_t'(res);
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $finish;
   endtask

   task automatic send_frame(input calc_pkg::data_t data, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, data, 1'b0}; // Start bit goes out first.
      repeat (10) begin
         @(posedge i_clk);
         i_rx <= bits[0];
         bits = bits >> 1;
         repeat (BIT_CLKS - 1) @(posedge i_clk);
      end
   endtask

   task automatic idle_bits(input int n);
      @(posedge i_clk);
      i_rx <= 1'b1;
      repeat (n * BIT_CLKS - 1) @(posedge i_clk);
   endtask

   task automatic push_result(input calc_pkg::data_t x, input calc_pkg::data_t opc,
         input calc_pkg::data_t y);
      @(posedge i_clk);
      push      <= 1'b1;
      push_byte <= expected_result(x, opc, y);
      @(posedge i_clk);
      push <= 1'b0;
   endtask

   task automatic note_bad_frame();
      @(posedge i_clk);
      expect_ferr <= 1'b1;
      @(posedge i_clk);
      expect_ferr <= 1'b0;
   endtask

   task automatic send_command(input calc_pkg::data_t x, input calc_pkg::data_t opc,
         input calc_pkg::data_t y);
      push_result(x, opc, y); // Announced before the frame can start.
      send_frame(x, 1'b1);
      send_frame(opc, 1'b1);
      send_frame(y, 1'b1);
   endtask

   task automatic wait_result(input string what);
      int cycles;
      cycles = 0;
      @(negedge i_clk);
      while (((u_checker.pending_count != 0) || u_checker.busy) && (cycles < DRAIN_LIMIT)) begin
         cycles++;
         @(negedge i_clk);
      end
      if ((u_checker.pending_count != 0) || u_checker.busy) begin
         abort_run($sformatf("Timeout: no result frame for the %s after %0d clocks",
                             what, DRAIN_LIMIT));
      end else begin
         idle_bits(1); // Lets the stop bit end so the sequencer is back in SEQ_LOAD_A.
      end
   endtask

   task automatic watch_idle(input int n);
      logic seen_low;
      seen_low = 1'b0;
      repeat (n * BIT_CLKS) begin
         @(negedge i_clk);
         if ((o_tx !== 1'b1) && !seen_low) begin
            seen_low = 1'b1;
            tb_errors++;
            $display("** Error at %0t ns: o_tx = %b, expected 1", $time, o_tx);
         end
      end
   endtask

   initial begin
      i_rx_done   = 1'b1;
      i_rx        = 1'b1; // Idle line.
      push        = 1'b0;
      push_byte   = '0;
      expect_ferr = 1'b0;
      repeat (10) @(posedge i_clk);
      i_rx_done <= 1'b0;
      watch_idle(4); // Nothing is sent after reset.
      send_frame(8'h37, 1'b1);
      send_frame(calc_pkg::CHAR_SUB, 1'b1);
      watch_idle(3); // Two bytes of a command are not enough.
      push_result(8'h37, calc_pkg::CHAR_SUB, 8'h39);
      send_frame(8'h39, 1'b1); // 7 - 9 wraps to 254.
      wait_result("command after reset");
      for (int k = 0; k < 40; k++) begin
         random_digit(a);
         take_bits(2, r);
         op = pick_operator(r[1:0]);
         random_digit(b);
         send_command(a, op, b);
         wait_result("random command");
      end
      repeat (4) begin
         random_digit(a);
         take_bits(8, r);
         op = r;
         if (op inside {calc_pkg::CHAR_ADD, calc_pkg::CHAR_SUB, calc_pkg::CHAR_AND,
                        calc_pkg::CHAR_OR}) op = op ^ 8'h01; // Step off a real operator.
         random_digit(b);
         send_command(a, op, b);
         wait_result("command with an unknown operator");
      end
      random_digit(a);
      take_bits(2, r);
      op = pick_operator(r[1:0]);
      random_digit(b);
      note_bad_frame();
      push_result(a, op, b);
      send_frame(a, 1'b1);
      send_frame(op, 1'b0); // Low stop bit, so this byte must not count.
      idle_bits(1);
      send_frame(op, 1'b1);
      send_frame(b, 1'b1);
      wait_result("command with a framing error");
      random_digit(a);
      take_bits(2, r);
      op = pick_operator(r[1:0]);
      random_digit(b);
      send_command(a, op, b);
      take_bits(8, r);
      send_frame(r, 1'b1); // Arrives while the result is still on o_tx.
      wait_result("command followed by an extra byte");
      random_digit(a);
      take_bits(2, r);
      op = pick_operator(r[1:0]);
      random_digit(b);
      send_command(a, op, b);
      wait_result("command after a dropped byte");
      idle_bits(12); // Any stray frame would show up here.
      @(negedge i_clk);
      if (u_checker.ferr_seen != u_checker.ferr_expected) begin
         tb_errors++;
         $display("o_frame_error pulsed %0d times but %0d bad frames were sent",
                  u_checker.ferr_seen, u_checker.ferr_expected);
      end
      $display("Error counts: %0d result mismatches, %0d protocol errors, %0d testbench errors",
               u_checker.mismatch_count, u_checker.protocol_count, tb_errors);
      if ((u_checker.mismatch_count + u_checker.protocol_count + tb_errors) == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
hw/calc_pkg.sv
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/uart_receiver.sv
hw/uart_transmitter.sv
hw/alu.sv
hw/command_sequencer.sv
hw/uart_calculator_top.sv
verification/calc_checker.sv
verification/tb_uart_calculator.sv

// File: run_sim.sh
#!/bin/sh
# Builds the serial calculator testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_uart_calculator -f sources.f -o sim_uart_calculator
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_uart_calculator)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation binary returned status $status"
   exit 1
fi

# The run passes only if the testbench printed its pass line.
if echo "$output" | grep -qx "Simulation completed successfully"; then
   exit 0
fi
exit 1
